// ==== design/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  wire                clk,
    input  wire                rst,
    input  ctrlPkg::opcodeT    opcode,
    input  wire                intReq,
    output ctrlPkg::ctrlWordT  ctrl,
    output logic               updatePC
);

    // decoder to sequencer and strobes
    ctrlPkg::instrClassT instrClass;
    ctrlPkg::staticCtrlT staticCtrl;
    logic                rTypeDst;
    ctrlPkg::stepT       lastStep;
    logic                isHalt;

    // sequencer outputs
    logic                capture;
    ctrlPkg::stepT       step;
    logic                running;
    logic                finish;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    opcodeDecoder decoder (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .capture    (capture),
        .instrClass (instrClass),
        .staticCtrl (staticCtrl),
        .rTypeDst   (rTypeDst),
        .lastStep   (lastStep),
        .isHalt     (isHalt)
    );

    stepSequencer sequencer (
        .clk      (clk),
        .rst      (rst),
        .lastStep (lastStep),
        .isHalt   (isHalt),
        .intReq   (intReq),
        .capture  (capture),
        .step     (step),
        .running  (running),
        .finish   (finish)
    );

    strobeGenerator strobes (
        .clk        (clk),
        .rst        (rst),
        .instrClass (instrClass),
        .staticCtrl (staticCtrl),
        .rTypeDst   (rTypeDst),
        .step       (step),
        .running    (running),
        .finish     (finish),
        .ctrl       (ctrl),
        .updatePC   (updatePC)
    );

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [3:0] aluOpT;
    typedef logic [2:0] branchOpT;
    typedef logic [2:0] stackOpT;
    typedef logic [3:0] stepT;   // step within one instruction, 0..8

    //////////////////////////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////////////////////////

    localparam opcodeT OP_RTYPE = 6'd0;
    localparam opcodeT OP_ADDI  = 6'd1;
    localparam opcodeT OP_SUBI  = 6'd2;
    localparam opcodeT OP_ANDI  = 6'd3;
    localparam opcodeT OP_ORI   = 6'd4;
    localparam opcodeT OP_XORI  = 6'd5;
    localparam opcodeT OP_NOTI  = 6'd6;
    localparam opcodeT OP_SLAI  = 6'd7;
    localparam opcodeT OP_SRLI  = 6'd8;
    localparam opcodeT OP_SRAI  = 6'd9;
    localparam opcodeT OP_BR    = 6'd10;
    localparam opcodeT OP_BMI   = 6'd11;
    localparam opcodeT OP_BPL   = 6'd12;
    localparam opcodeT OP_BZ    = 6'd13;
    localparam opcodeT OP_LD    = 6'd14;
    localparam opcodeT OP_ST    = 6'd15;
    localparam opcodeT OP_MOVE  = 6'd18;
    localparam opcodeT OP_PUSH  = 6'd19;
    localparam opcodeT OP_POP   = 6'd20;
    localparam opcodeT OP_CALL  = 6'd21;
    localparam opcodeT OP_HALT  = 6'd22;
    localparam opcodeT OP_NOP   = 6'd23;
    localparam opcodeT OP_RET   = 6'd24;
    localparam opcodeT OP_NORI  = 6'd25;   // late additions to the i-type set
    localparam opcodeT OP_SLTI  = 6'd26;
    localparam opcodeT OP_SGTI  = 6'd27;

    //////////////////////////////////////////////////////////////////////
    // control field encodings
    //////////////////////////////////////////////////////////////////////

    localparam aluOpT ALU_PASS = 4'd0;
    localparam aluOpT ALU_ADD  = 4'd1;   // addresses, branches, move, stack

    localparam branchOpT BR_NONE   = 3'd0;
    localparam branchOpT BR_ALWAYS = 3'd1;
    localparam branchOpT BR_PLUS   = 3'd2;
    localparam branchOpT BR_MINUS  = 3'd3;
    localparam branchOpT BR_ZERO   = 3'd4;

    localparam stackOpT ST_NONE = 3'd0;
    localparam stackOpT ST_PUSH = 3'd1;
    localparam stackOpT ST_POP  = 3'd2;
    localparam stackOpT ST_CALL = 3'd3;
    localparam stackOpT ST_RET  = 3'd4;

    localparam stepT SETUP_STEP = 4'd3;   // static fields load here

    typedef enum logic [3:0] {
        CL_ALU,      // r-type, i-type alu and move
        CL_BRANCH,
        CL_LOAD,
        CL_STORE,
        CL_PUSH,
        CL_POP,
        CL_CALL,
        CL_RET,
        CL_HALT,
        CL_NOP
    } instrClassT;

    // full control word, 16 bits
    typedef struct packed {
        branchOpT branchOp;
        aluOpT    aluOp;
        logic     aluSrc;
        logic     memR;
        logic     memW;
        logic     regW;
        logic     regDst;
        logic     memToReg;
        stackOpT  stackOp;
    } ctrlWordT;

    typedef struct packed {
        branchOpT branchOp;
        aluOpT    aluOp;
        logic     aluSrc;
        stackOpT  stackOp;
    } staticCtrlT;

endpackage

`default_nettype wire

// ==== design/opcodeDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module opcodeDecoder (
    input  wire                  clk,
    input  wire                  rst,
    input  ctrlPkg::opcodeT      opcode,
    input  wire                  capture,
    output ctrlPkg::instrClassT  instrClass,
    output ctrlPkg::staticCtrlT  staticCtrl,
    output logic                 rTypeDst,
    output ctrlPkg::stepT        lastStep,
    output logic                 isHalt
);

    // last step per class, period is lastStep + 2
    localparam ctrlPkg::stepT LAST_SHORT = 4'd4;   // halt, nop
    localparam ctrlPkg::stepT LAST_ALU   = 4'd5;   // alu, branch
    localparam ctrlPkg::stepT LAST_MEM   = 4'd6;   // load, store, push, ret
    localparam ctrlPkg::stepT LAST_CALL  = 4'd7;
    localparam ctrlPkg::stepT LAST_POP   = 4'd8;

    ctrlPkg::opcodeT instrReg;

    // instruction register, loads on the edge that ends fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            instrReg <= ctrlPkg::OP_NOP;
        end else if (capture) begin
            instrReg <= opcode;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // opcode table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // defaults describe a nop
        instrClass          = ctrlPkg::CL_NOP;
        staticCtrl.branchOp = ctrlPkg::BR_NONE;
        staticCtrl.aluOp    = ctrlPkg::ALU_PASS;
        staticCtrl.aluSrc   = 1'b0;
        staticCtrl.stackOp  = ctrlPkg::ST_NONE;
        rTypeDst            = 1'b0;
        lastStep            = LAST_SHORT;

        case (instrReg)
            ctrlPkg::OP_RTYPE: begin
                instrClass = ctrlPkg::CL_ALU;
                rTypeDst   = 1'b1;   // result goes to rd
                lastStep   = LAST_ALU;
            end
            ctrlPkg::OP_ADDI, ctrlPkg::OP_SUBI, ctrlPkg::OP_ANDI, ctrlPkg::OP_ORI,
            ctrlPkg::OP_XORI, ctrlPkg::OP_NOTI, ctrlPkg::OP_SLAI, ctrlPkg::OP_SRLI,
            ctrlPkg::OP_SRAI, ctrlPkg::OP_NORI, ctrlPkg::OP_SLTI, ctrlPkg::OP_SGTI: begin
                instrClass        = ctrlPkg::CL_ALU;
                staticCtrl.aluOp  = instrReg[3:0];   // alu op straight from opcode
                staticCtrl.aluSrc = 1'b1;
                lastStep          = LAST_ALU;
            end
            ctrlPkg::OP_MOVE: begin
                // rt = rs + 0
                instrClass        = ctrlPkg::CL_ALU;
                staticCtrl.aluOp  = ctrlPkg::ALU_ADD;
                staticCtrl.aluSrc = 1'b1;
                lastStep          = LAST_ALU;
            end
            ctrlPkg::OP_BR, ctrlPkg::OP_BPL, ctrlPkg::OP_BMI, ctrlPkg::OP_BZ: begin
                instrClass        = ctrlPkg::CL_BRANCH;
                staticCtrl.aluOp  = ctrlPkg::ALU_ADD;   // pc + imm
                staticCtrl.aluSrc = 1'b1;
                lastStep          = LAST_ALU;
                case (instrReg)
                    ctrlPkg::OP_BR:  staticCtrl.branchOp = ctrlPkg::BR_ALWAYS;
                    ctrlPkg::OP_BPL: staticCtrl.branchOp = ctrlPkg::BR_PLUS;
                    ctrlPkg::OP_BMI: staticCtrl.branchOp = ctrlPkg::BR_MINUS;
                    default:         staticCtrl.branchOp = ctrlPkg::BR_ZERO;
                endcase
            end
            ctrlPkg::OP_LD, ctrlPkg::OP_ST: begin
                instrClass        = (instrReg == ctrlPkg::OP_LD) ? ctrlPkg::CL_LOAD
                                                                 : ctrlPkg::CL_STORE;
                staticCtrl.aluOp  = ctrlPkg::ALU_ADD;   // base + offset
                staticCtrl.aluSrc = 1'b1;
                lastStep          = LAST_MEM;
            end
            ctrlPkg::OP_PUSH: begin
                instrClass         = ctrlPkg::CL_PUSH;
                staticCtrl.aluOp   = ctrlPkg::ALU_ADD;
                staticCtrl.aluSrc  = 1'b1;
                staticCtrl.stackOp = ctrlPkg::ST_PUSH;
                lastStep           = LAST_MEM;
            end
            ctrlPkg::OP_POP: begin
                instrClass         = ctrlPkg::CL_POP;
                staticCtrl.aluOp   = ctrlPkg::ALU_ADD;
                staticCtrl.aluSrc  = 1'b1;
                staticCtrl.stackOp = ctrlPkg::ST_POP;
                lastStep           = LAST_POP;   // two register writes
            end
            ctrlPkg::OP_CALL: begin
                instrClass         = ctrlPkg::CL_CALL;
                staticCtrl.aluOp   = ctrlPkg::ALU_ADD;
                staticCtrl.aluSrc  = 1'b1;
                staticCtrl.stackOp = ctrlPkg::ST_CALL;
                lastStep           = LAST_CALL;
            end
            ctrlPkg::OP_RET: begin
                instrClass         = ctrlPkg::CL_RET;
                staticCtrl.aluOp   = ctrlPkg::ALU_ADD;
                staticCtrl.aluSrc  = 1'b1;
                staticCtrl.stackOp = ctrlPkg::ST_RET;
                lastStep           = LAST_MEM;
            end
            ctrlPkg::OP_HALT: begin
                instrClass = ctrlPkg::CL_HALT;
            end
            default: ;   // nop and unknown opcodes
        endcase
    end

    assign isHalt = (instrClass == ctrlPkg::CL_HALT);

endmodule

`default_nettype wire

// ==== design/stepSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
    input  wire            clk,
    input  wire            rst,
    input  ctrlPkg::stepT  lastStep,
    input  wire            isHalt,
    input  wire            intReq,
    output logic           capture,
    output ctrlPkg::stepT  step,
    output logic           running,
    output logic           finish
);

    typedef enum logic [1:0] {
        SEQ_FETCH,
        SEQ_RUN,
        SEQ_WAIT   // halt parked at the setup step
    } seqStateT;

    seqStateT      state;
    ctrlPkg::stepT stepCnt;
    logic          haltHold;

    // halt stays put at the setup step without an interrupt
    assign haltHold = isHalt && !intReq && (stepCnt == ctrlPkg::SETUP_STEP);

    //////////////////////////////////////////////////////////////////////
    // state and step counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SEQ_FETCH;
            stepCnt <= '0;
        end else begin
            case (state)
                SEQ_FETCH: begin
                    state <= SEQ_RUN;   // opcode captured on this edge
                end
                SEQ_RUN: begin
                    if (finish) begin
                        state   <= SEQ_FETCH;
                        stepCnt <= '0;
                    end else if (haltHold) begin
                        state <= SEQ_WAIT;
                    end else begin
                        stepCnt <= stepCnt + ctrlPkg::stepT'(1);
                    end
                end
                SEQ_WAIT: begin
                    if (intReq) begin
                        state   <= SEQ_RUN;
                        stepCnt <= stepCnt + ctrlPkg::stepT'(1);
                    end
                end
                default: begin
                    state   <= SEQ_FETCH;
                    stepCnt <= '0;
                end
            endcase
        end
    end

    assign capture = (state == SEQ_FETCH);
    assign running = (state != SEQ_FETCH);
    assign step    = stepCnt;
    assign finish  = running && (stepCnt == lastStep);   // high during the last step

endmodule

`default_nettype wire

// ==== design/strobeGenerator.sv ====
`timescale 1ns/1ns
`default_nettype none

module strobeGenerator (
    input  wire                  clk,
    input  wire                  rst,
    input  ctrlPkg::instrClassT  instrClass,
    input  ctrlPkg::staticCtrlT  staticCtrl,
    input  wire                  rTypeDst,
    input  ctrlPkg::stepT        step,
    input  wire                  running,
    input  wire                  finish,
    output ctrlPkg::ctrlWordT    ctrl,
    output logic                 updatePC
);

    logic setupDst;
    logic setupMemToReg;

    // register destination and write source at setup
    always_comb begin
        case (instrClass)
            ctrlPkg::CL_ALU:  setupDst = rTypeDst;
            ctrlPkg::CL_PUSH,
            ctrlPkg::CL_CALL,
            ctrlPkg::CL_RET:  setupDst = 1'b1;   // sp lives in rd
            default:          setupDst = 1'b0;
        endcase
        setupMemToReg = (instrClass == ctrlPkg::CL_POP);   // pop writes lmd first
    end

    //////////////////////////////////////////////////////////////////////
    // control word register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= '0;
            updatePC <= 1'b0;
        end else begin
            updatePC <= finish;   // lands in the following fetch cycle

            if (running && step == ctrlPkg::SETUP_STEP) begin
                ctrl.branchOp <= staticCtrl.branchOp;
                ctrl.aluOp    <= staticCtrl.aluOp;
                ctrl.aluSrc   <= staticCtrl.aluSrc;
                ctrl.stackOp  <= staticCtrl.stackOp;
                ctrl.regDst   <= setupDst;
                ctrl.memToReg <= setupMemToReg;
                ctrl.memR     <= 1'b0;
                ctrl.memW     <= 1'b0;
                ctrl.regW     <= 1'b0;
            end else if (running) begin
                // tail strobes
                case (instrClass)
                    ctrlPkg::CL_ALU: begin
                        case (step)
                            4'd4: ctrl.regW <= 1'b1;
                            4'd5: ctrl.regW <= 1'b0;
                            default: ;
                        endcase
                    end
                    ctrlPkg::CL_LOAD: begin
                        case (step)
                            4'd4: ctrl.memR <= 1'b1;
                            4'd5: begin
                                ctrl.memR     <= 1'b0;
                                ctrl.memToReg <= 1'b1;
                                ctrl.regW     <= 1'b1;
                            end
                            4'd6: begin
                                ctrl.memToReg <= 1'b0;
                                ctrl.regW     <= 1'b0;
                            end
                            default: ;
                        endcase
                    end
                    ctrlPkg::CL_STORE: begin
                        case (step)
                            4'd5: ctrl.memW <= 1'b1;   // step 4 leaves the address settling
                            4'd6: ctrl.memW <= 1'b0;
                            default: ;
                        endcase
                    end
                    ctrlPkg::CL_PUSH, ctrlPkg::CL_CALL: begin
                        // sp update, then the memory write
                        case (step)
                            4'd4: ctrl.regW <= 1'b1;
                            4'd5: begin
                                ctrl.regW <= 1'b0;
                                ctrl.memW <= 1'b1;
                            end
                            4'd6: ctrl.memW <= 1'b0;
                            default: ;
                        endcase
                    end
                    ctrlPkg::CL_POP: begin
                        case (step)
                            4'd4: ctrl.memR <= 1'b1;
                            4'd5: begin
                                ctrl.memR <= 1'b0;
                                ctrl.regW <= 1'b1;   // rt from memory
                            end
                            4'd6: begin
                                ctrl.regW     <= 1'b0;
                                ctrl.regDst   <= 1'b1;
                                ctrl.memToReg <= 1'b0;
                            end
                            4'd7: ctrl.regW <= 1'b1;   // sp into rd
                            4'd8: ctrl.regW <= 1'b0;
                            default: ;
                        endcase
                    end
                    ctrlPkg::CL_RET: begin
                        case (step)
                            4'd4: ctrl.memR <= 1'b1;   // return address
                            4'd5: begin
                                ctrl.memR <= 1'b0;
                                ctrl.regW <= 1'b1;
                            end
                            4'd6: ctrl.regW <= 1'b0;
                            default: ;
                        endcase
                    end
                    default: ;   // branch, halt, nop drive no strobes
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module controlUnitTb -f tb.f -o simv

out=$(./obj_dir/simv) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Simulation PASSED"

// ==== tb.f ====
design/ctrlPkg.sv
design/opcodeDecoder.sv
design/stepSequencer.sv
design/strobeGenerator.sv
design/controlUnit.sv
tb/controlUnitTb.sv

// ==== tb/controlUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

    localparam int WAIT_LIMIT = 20;   // cycles per instruction before giving up

    // one table row, expected values from the instruction set rules
    typedef struct packed {
        ctrlPkg::opcodeT     op;
        ctrlPkg::stepT       irqDelay;   // edges after capture until intReq rises
        ctrlPkg::stepT       period;
        ctrlPkg::stepT       nRegW;
        ctrlPkg::stepT       nMemR;
        ctrlPkg::stepT       nMemW;
        ctrlPkg::staticCtrlT stat;
        logic [1:0]          dst;        // regDst per regW pulse, bit 0 first
        logic [1:0]          m2r;        // memToReg per regW pulse
    } rowT;

    logic              clk;
    logic              rst;
    ctrlPkg::opcodeT   opcode;
    logic              intReq;
    ctrlPkg::ctrlWordT ctrl;
    logic              updatePC;

    rowT    rows[$];
    integer seed;

    controlUnit DUT (
        .clk      (clk),
        .rst      (rst),
        .opcode   (opcode),
        .intReq   (intReq),
        .ctrl     (ctrl),
        .updatePC (updatePC)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // compare helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic compareCtrl(input string name, input ctrlPkg::ctrlWordT got,
                               input ctrlPkg::ctrlWordT exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verifyStatic(input string name, input ctrlPkg::staticCtrlT got,
                                input ctrlPkg::staticCtrlT exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic matchCount(input string name, input ctrlPkg::stepT got,
                              input ctrlPkg::stepT exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expectBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic addRow(input ctrlPkg::opcodeT op, input ctrlPkg::stepT irqDelay,
                          input ctrlPkg::stepT period, input ctrlPkg::stepT nRegW,
                          input ctrlPkg::stepT nMemR, input ctrlPkg::stepT nMemW,
                          input ctrlPkg::branchOpT br, input ctrlPkg::aluOpT alu,
                          input logic src, input ctrlPkg::stackOpT st,
                          input logic [1:0] dst, input logic [1:0] m2r);
        rowT r;
        r.op            = op;
        r.irqDelay      = irqDelay;
        r.period        = period;
        r.nRegW         = nRegW;
        r.nMemR         = nMemR;
        r.nMemW         = nMemW;
        r.stat.branchOp = br;
        r.stat.aluOp    = alu;
        r.stat.aluSrc   = src;
        r.stat.stackOp  = st;
        r.dst           = dst;
        r.m2r           = m2r;
        rows.push_back(r);
    endtask

    // intReq late enough that the halt parks, 4..11 edges
    function automatic ctrlPkg::stepT randomDelay();
        randomDelay = ctrlPkg::stepT'(4 + $unsigned($random(seed)) % 8);
    endfunction

    task automatic fillTable();
        ctrlPkg::opcodeT iTypes[12];
        ctrlPkg::stepT   d;
        iTypes = '{ctrlPkg::OP_ADDI, ctrlPkg::OP_SUBI, ctrlPkg::OP_ANDI, ctrlPkg::OP_ORI,
                   ctrlPkg::OP_XORI, ctrlPkg::OP_NOTI, ctrlPkg::OP_SLAI, ctrlPkg::OP_SRLI,
                   ctrlPkg::OP_SRAI, ctrlPkg::OP_NORI, ctrlPkg::OP_SLTI, ctrlPkg::OP_SGTI};
        addRow(ctrlPkg::OP_RTYPE, 4'd0, 4'd7, 4'd1, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_PASS, 1'b0, ctrlPkg::ST_NONE, 2'b01, 2'b00);
        foreach (iTypes[i]) begin
            addRow(iTypes[i], 4'd0, 4'd7, 4'd1, 4'd0, 4'd0,
                   ctrlPkg::BR_NONE, iTypes[i][3:0], 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        end
        addRow(ctrlPkg::OP_MOVE, 4'd0, 4'd7, 4'd1, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        // branches, no strobes at all
        addRow(ctrlPkg::OP_BR, 4'd0, 4'd7, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_ALWAYS, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(ctrlPkg::OP_BMI, 4'd0, 4'd7, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_MINUS, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(ctrlPkg::OP_BPL, 4'd0, 4'd7, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_PLUS, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(ctrlPkg::OP_BZ, 4'd0, 4'd7, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_ZERO, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        // memory and stack classes
        addRow(ctrlPkg::OP_LD, 4'd0, 4'd8, 4'd1, 4'd1, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b01);
        addRow(ctrlPkg::OP_ST, 4'd0, 4'd8, 4'd0, 4'd0, 4'd1,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(ctrlPkg::OP_PUSH, 4'd0, 4'd8, 4'd1, 4'd0, 4'd1,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_PUSH, 2'b01, 2'b00);
        addRow(ctrlPkg::OP_POP, 4'd0, 4'd10, 4'd2, 4'd1, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_POP, 2'b10, 2'b01);
        addRow(ctrlPkg::OP_CALL, 4'd0, 4'd9, 4'd1, 4'd0, 4'd1,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_CALL, 2'b01, 2'b00);
        addRow(ctrlPkg::OP_RET, 4'd0, 4'd8, 4'd1, 4'd1, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_ADD, 1'b1, ctrlPkg::ST_RET, 2'b01, 2'b00);
        // halt, nop and an unused opcode
        addRow(ctrlPkg::OP_HALT, 4'd0, 4'd6, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_PASS, 1'b0, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        d = randomDelay();
        // updatePC rises 2 edges after intReq and is seen one edge later
        addRow(ctrlPkg::OP_HALT, d, d + 4'd3, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_PASS, 1'b0, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(ctrlPkg::OP_NOP, 4'd0, 4'd6, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_PASS, 1'b0, ctrlPkg::ST_NONE, 2'b00, 2'b00);
        addRow(6'd40, 4'd0, 4'd6, 4'd0, 4'd0, 4'd0,
               ctrlPkg::BR_NONE, ctrlPkg::ALU_PASS, 1'b0, ctrlPkg::ST_NONE, 2'b00, 2'b00);
    endtask

    //////////////////////////////////////////////////////////////////////
    // one instruction, from capture edge to the next capture edge
    //////////////////////////////////////////////////////////////////////

    task automatic runInstr(input rowT row);
        int                  n;
        int                  firstRegW;
        int                  firstMemR;
        int                  firstMemW;
        ctrlPkg::stepT       nRegW;
        ctrlPkg::stepT       nMemR;
        ctrlPkg::stepT       nMemW;
        ctrlPkg::staticCtrlT stat;
        logic                seen;
        n         = 0;
        firstRegW = 0;
        firstMemR = 0;
        firstMemW = 0;
        nRegW     = 4'd0;
        nMemR     = 4'd0;
        nMemW     = 4'd0;
        seen      = 1'b0;
        while (!seen) begin
            @(posedge clk);   // values below are from the cycle just ended
            n++;
            if (n > WAIT_LIMIT) begin
                abortRun($sformatf("updatePC never arrived for opcode 0x%h", row.op));
            end
            if (n == int'(row.irqDelay)) begin
                intReq <= 1'b1;
            end
            if (ctrl.memR) begin
                if (nMemR == 4'd0) begin
                    firstMemR = n;
                end
                nMemR = nMemR + 4'd1;
            end
            if (ctrl.memW) begin
                if (nMemW == 4'd0) begin
                    firstMemW = n;
                end
                nMemW = nMemW + 4'd1;
            end
            if (ctrl.regW) begin
                if (nRegW == 4'd0) begin
                    firstRegW = n;
                end
                if (nRegW < 4'd2) begin
                    expectBit("regDst", ctrl.regDst, row.dst[nRegW[0]]);
                    expectBit("memToReg", ctrl.memToReg, row.m2r[nRegW[0]]);
                end
                nRegW = nRegW + 4'd1;
            end
            seen = updatePC;
        end

        stat.branchOp = ctrl.branchOp;
        stat.aluOp    = ctrl.aluOp;
        stat.aluSrc   = ctrl.aluSrc;
        stat.stackOp  = ctrl.stackOp;
        verifyStatic("staticCtrl", stat, row.stat);
        matchCount("period", ctrlPkg::stepT'(n), row.period);
        matchCount("regW count", nRegW, row.nRegW);
        matchCount("memR count", nMemR, row.nMemR);
        matchCount("memW count", nMemW, row.nMemW);
        if (nMemR != 4'd0 && nRegW != 4'd0 && firstMemR >= firstRegW) begin
            abortRun($sformatf("memR did not come before regW for opcode 0x%h", row.op));
        end
        if (nRegW != 4'd0 && nMemW != 4'd0 && firstRegW >= firstMemW) begin
            abortRun($sformatf("regW did not come before memW for opcode 0x%h", row.op));
        end
    endtask

    initial begin
        int  nDir;
        int  idx;
        rowT r;
        rst    <= 1'b1;
        opcode <= ctrlPkg::OP_NOP;
        intReq <= 1'b0;
        seed = 32'hbd4c;
        fillTable();

        // shuffled repeats of the directed rows
        nDir = rows.size();
        for (int i = 0; i < 12; i++) begin
            idx = $unsigned($random(seed)) % nDir;
            r   = rows[idx];
            if (r.op == ctrlPkg::OP_HALT && r.irqDelay != 4'd0) begin
                r.irqDelay = randomDelay();
                r.period   = r.irqDelay + 4'd3;
            end
            rows.push_back(r);
        end

        @(posedge clk);
        opcode <= rows[0].op;   // first instruction waits on the bus during reset
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);   // end of the first fetch cycle
        compareCtrl("ctrl", ctrl, '0);
        expectBit("updatePC", updatePC, 1'b0);

        foreach (rows[k]) begin
            // next opcode goes out on the edge that captures this one
            opcode <= (k + 1 < rows.size()) ? rows[k + 1].op : ctrlPkg::OP_NOP;
            intReq <= (rows[k].irqDelay == 4'd0);
            runInstr(rows[k]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
